// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := core_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test OK

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(OBJ_DIR)/V%: $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(OBJ_DIR) -o V$* -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath width
`define XLEN		32

// register file geometry
`define REG_AW		5
`define REG_NUM		32

`define RESET_PC	32'h0000_0000

// destination for bubbles, never written
`define NOP_REG		5'd0

`endif

// ==== design/core_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

// two read ports, data comes back in the same cycle
interface rf_read_if;
	logic				r1_en;
	logic				r2_en;
	logic [`REG_AW-1:0]	r1_addr;
	logic [`REG_AW-1:0]	r2_addr;
	logic [`XLEN-1:0]	r1_data;
	logic [`XLEN-1:0]	r2_data;

	modport dec (output r1_en, r2_en, r1_addr, r2_addr, input r1_data, r2_data);
	modport rf (input r1_en, r2_en, r1_addr, r2_addr, output r1_data, r2_data);
endinterface

// decoded bundle, registered by exec every cycle
interface id_ex_if
	import core_pipe_pkg::*;
();
	alu_op_e			aluop;
	alu_sel_e			alusel;
	logic [`XLEN-1:0]	op1;
	logic [`XLEN-1:0]	op2;
	logic				w_en;
	logic [`REG_AW-1:0]	w_addr;

	modport dec (output aluop, alusel, op1, op2, w_en, w_addr);
	modport ex (input aluop, alusel, op1, op2, w_en, w_addr);
endinterface

`default_nettype wire

// ==== design/core_pipe_pkg.sv ====
`default_nettype none

package core_pipe_pkg;

	typedef enum logic [3:0]
	{
		NOP,
		ADD,
		SUB,
		SLT,
		SLTU,
		AND,
		OR,
		XOR,
		SLL,
		SRL,
		SRA
	} alu_op_e;

	// which alu result gets committed
	typedef enum logic [1:0]
	{
		NONE,
		ARITH,
		LOGIC,
		SHIFT
	} alu_sel_e;

endpackage

`default_nettype wire

// ==== design/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_top
(
	input  wire					clk,
	input  wire					rst,
	input  wire [`XLEN-1:0]		inst_i,
	output wire [`XLEN-1:0]		inst_addr_o,
	output wire					wb_en_o,
	output wire [`REG_AW-1:0]	wb_addr_o,
	output wire [`XLEN-1:0]		wb_data_o
);

	wire [`XLEN-1:0]	if_inst;

	wire				ex_w_en;
	wire [`REG_AW-1:0]	ex_w_addr;
	wire [`XLEN-1:0]	ex_w_data;

	wire				mem_w_en;
	wire [`REG_AW-1:0]	mem_w_addr;
	wire [`XLEN-1:0]	mem_w_data;

	rf_read_if	rf_bus ();
	id_ex_if	id_ex_bus ();

	fetch_stage u_fetch
	(
		.clk			(clk),
		.rst			(rst),
		.inst_i			(inst_i),
		.inst_addr_o	(inst_addr_o),
		.if_inst_o		(if_inst)
	);

	decode_stage u_decode
	(
		.inst_i			(if_inst),
		.rf				(rf_bus),
		.ex				(id_ex_bus),
		.ex_w_en_i		(ex_w_en),
		.ex_w_addr_i	(ex_w_addr),
		.ex_w_data_i	(ex_w_data),
		.mem_w_en_i		(mem_w_en),
		.mem_w_addr_i	(mem_w_addr),
		.mem_w_data_i	(mem_w_data)
	);

	regfile u_regfile
	(
		.clk			(clk),
		.rst			(rst),
		.rf				(rf_bus),
		.w_en_i			(wb_en_o),
		.w_addr_i		(wb_addr_o),
		.w_data_i		(wb_data_o)
	);

	exec_pipe u_exec
	(
		.clk			(clk),
		.rst			(rst),
		.id				(id_ex_bus),
		.ex_w_en_o		(ex_w_en),
		.ex_w_addr_o	(ex_w_addr),
		.ex_w_data_o	(ex_w_data),
		.mem_w_en_o		(mem_w_en),
		.mem_w_addr_o	(mem_w_addr),
		.mem_w_data_o	(mem_w_data),
		.wb_en_o		(wb_en_o),
		.wb_addr_o		(wb_addr_o),
		.wb_data_o		(wb_data_o)
	);

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module decode_stage
	import rv_isa_pkg::*;
	import core_pipe_pkg::*;
(
	input  wire [`XLEN-1:0]		inst_i,
	rf_read_if.dec				rf,
	id_ex_if.dec				ex,

	input  wire					ex_w_en_i,
	input  wire [`REG_AW-1:0]	ex_w_addr_i,
	input  wire [`XLEN-1:0]		ex_w_data_i,

	input  wire					mem_w_en_i,
	input  wire [`REG_AW-1:0]	mem_w_addr_i,
	input  wire [`XLEN-1:0]		mem_w_data_i
);

	opcode_e			opcode;
	funct3_e			funct3;
	funct7_e			funct7;
	logic [`REG_AW-1:0]	rd;
	logic [`REG_AW-1:0]	rs1;
	logic [`REG_AW-1:0]	rs2;
	logic				base7;
	logic				alt7;
	logic [`XLEN-1:0]	imm_i;
	logic [`XLEN-1:0]	imm_u;
	logic [`XLEN-1:0]	imm_sh;
	logic [`XLEN-1:0]	imm;
	logic				valid;
	alu_op_e			aluop;
	alu_sel_e			alusel;
	logic				r1_en;
	logic				r2_en;
	logic [`REG_AW-1:0]	r1_addr;
	logic [`REG_AW-1:0]	r2_addr;

	// ex beats mem beats regfile, immediate when the read is off
	function automatic logic [`XLEN-1:0] pick_operand(
		input logic					en,
		input logic [`REG_AW-1:0]	addr,
		input logic [`XLEN-1:0]		rf_data
	);
		if (!en)
			return imm;
		if (ex_w_en_i && ex_w_addr_i == addr)
			return ex_w_data_i;
		if (mem_w_en_i && mem_w_addr_i == addr)
			return mem_w_data_i;
		return rf_data;
	endfunction

	assign opcode	= opcode_e'(inst_i[6:0]);
	assign rd		= inst_i[11:7];
	assign funct3	= funct3_e'(inst_i[14:12]);
	assign rs1		= inst_i[19:15];
	assign rs2		= inst_i[24:20];
	assign funct7	= funct7_e'(inst_i[31:25]);
	assign base7	= (funct7 == F7_BASE);
	assign alt7		= (funct7 == F7_ALT);

	assign imm_i	= {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
	assign imm_u	= {inst_i[31:12], 12'h000};
	// shamt sits in the rs2 field
	assign imm_sh	= {{(`XLEN-`REG_AW){1'b0}}, rs2};

	always_comb
	begin
		valid	= 1'b0;
		aluop	= NOP;
		alusel	= NONE;
		r1_en	= 1'b0;
		r2_en	= 1'b0;
		r1_addr	= rs1;
		r2_addr	= rs2;
		imm		= '0;

		case (opcode)
			OP_LUI:
			begin
				// x0 | imm
				valid	= 1'b1;
				r1_en	= 1'b1;
				r1_addr	= `NOP_REG;
				imm		= imm_u;
			end
			OP_OPI:
			begin
				valid	= 1'b1;
				r1_en	= 1'b1;
				imm		= imm_i;
				if (funct3 == F3_SLL)
					valid = base7;
				else if (funct3 == F3_SRL)
					valid = base7 || alt7;
				if (funct3 == F3_SLL || funct3 == F3_SRL)
					imm = imm_sh;
			end
			OP_OP:
			begin
				valid	= base7 || (alt7 && (funct3 == F3_ADD || funct3 == F3_SRL));
				r1_en	= 1'b1;
				r2_en	= 1'b1;
			end
			default:
			begin
				valid	= 1'b0;
			end
		endcase

		if (opcode == OP_LUI)
		begin
			aluop	= OR;
			alusel	= LOGIC;
		end
		else
		begin
			// same funct3 map for both integer groups
			case (funct3)
				F3_ADD:
				begin
					aluop	= (alt7 && opcode == OP_OP) ? SUB : ADD;
					alusel	= ARITH;
				end
				F3_SLT:
				begin
					aluop	= SLT;
					alusel	= ARITH;
				end
				F3_SLTU:
				begin
					aluop	= SLTU;
					alusel	= ARITH;
				end
				F3_XOR:
				begin
					aluop	= XOR;
					alusel	= LOGIC;
				end
				F3_OR:
				begin
					aluop	= OR;
					alusel	= LOGIC;
				end
				F3_AND:
				begin
					aluop	= AND;
					alusel	= LOGIC;
				end
				F3_SLL:
				begin
					aluop	= SLL;
					alusel	= SHIFT;
				end
				F3_SRL:
				begin
					aluop	= alt7 ? SRA : SRL;
					alusel	= SHIFT;
				end
				default:
				begin
					aluop	= NOP;
					alusel	= NONE;
				end
			endcase
		end

		// anything unrecognised leaves as a bubble
		if (!valid)
		begin
			aluop	= NOP;
			alusel	= NONE;
			r1_en	= 1'b0;
			r2_en	= 1'b0;
			r1_addr	= `NOP_REG;
			r2_addr	= `NOP_REG;
			imm		= '0;
		end
	end

	assign rf.r1_en		= r1_en;
	assign rf.r2_en		= r2_en;
	assign rf.r1_addr	= r1_addr;
	assign rf.r2_addr	= r2_addr;

	assign ex.aluop		= aluop;
	assign ex.alusel	= alusel;
	assign ex.w_en		= valid && (rd != `NOP_REG);
	assign ex.w_addr	= valid ? rd : `NOP_REG;

	always_comb
	begin
		ex.op1 = pick_operand(r1_en, r1_addr, rf.r1_data);
		ex.op2 = pick_operand(r2_en, r2_addr, rf.r2_data);
	end

endmodule

`default_nettype wire

// ==== design/exec_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module exec_pipe
	import core_pipe_pkg::*;
(
	input  wire					clk,
	input  wire					rst,
	id_ex_if.ex					id,

	output logic				ex_w_en_o,
	output logic [`REG_AW-1:0]	ex_w_addr_o,
	output logic [`XLEN-1:0]	ex_w_data_o,

	output logic				mem_w_en_o,
	output logic [`REG_AW-1:0]	mem_w_addr_o,
	output logic [`XLEN-1:0]	mem_w_data_o,

	output logic				wb_en_o,
	output logic [`REG_AW-1:0]	wb_addr_o,
	output logic [`XLEN-1:0]	wb_data_o
);

	alu_op_e			aluop_q;
	alu_sel_e			alusel_q;
	logic [`XLEN-1:0]	op1_q;
	logic [`XLEN-1:0]	op2_q;
	logic				w_en_q;
	logic [`REG_AW-1:0]	w_addr_q;
	logic [4:0]			shamt;
	logic [`XLEN-1:0]	arith_res;
	logic [`XLEN-1:0]	logic_res;
	logic [`XLEN-1:0]	shift_res;
	logic [`XLEN-1:0]	alu_res;

	// id/ex, ex/mem and mem/wb control
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			aluop_q		<= NOP;
			alusel_q	<= NONE;
			w_en_q		<= 1'b0;
			mem_w_en_o	<= 1'b0;
			wb_en_o		<= 1'b0;
		end
		else
		begin
			aluop_q		<= id.aluop;
			alusel_q	<= id.alusel;
			w_en_q		<= id.w_en;
			mem_w_en_o	<= w_en_q;
			wb_en_o		<= mem_w_en_o;
		end
	end

	// operands and write data
	always_ff @(posedge clk)
	begin
		op1_q			<= id.op1;
		op2_q			<= id.op2;
		w_addr_q		<= id.w_addr;
		mem_w_addr_o	<= w_addr_q;
		mem_w_data_o	<= alu_res;
		wb_addr_o		<= mem_w_addr_o;
		wb_data_o		<= mem_w_data_o;
	end

	// only the low 5 bits count
	assign shamt = op2_q[4:0];

	always_comb
	begin
		case (aluop_q)
			ADD:		arith_res = op1_q + op2_q;
			SUB:		arith_res = op1_q - op2_q;
			SLT:		arith_res = {{(`XLEN-1){1'b0}}, $signed(op1_q) < $signed(op2_q)};
			SLTU:		arith_res = {{(`XLEN-1){1'b0}}, op1_q < op2_q};
			default:	arith_res = '0;
		endcase

		case (aluop_q)
			AND:		logic_res = op1_q & op2_q;
			OR:			logic_res = op1_q | op2_q;
			XOR:		logic_res = op1_q ^ op2_q;
			default:	logic_res = '0;
		endcase

		case (aluop_q)
			SLL:		shift_res = op1_q << shamt;
			SRL:		shift_res = op1_q >> shamt;
			SRA:		shift_res = $unsigned($signed(op1_q) >>> shamt);
			default:	shift_res = '0;
		endcase

		case (alusel_q)
			ARITH:		alu_res = arith_res;
			LOGIC:		alu_res = logic_res;
			SHIFT:		alu_res = shift_res;
			default:	alu_res = '0;
		endcase
	end

	// ex tap straight from the alu
	assign ex_w_en_o	= w_en_q;
	assign ex_w_addr_o	= w_addr_q;
	assign ex_w_data_o	= alu_res;

endmodule

`default_nettype wire

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module fetch_stage
(
	input  wire					clk,
	input  wire					rst,
	input  wire [`XLEN-1:0]		inst_i,
	output logic [`XLEN-1:0]	inst_addr_o,
	output logic [`XLEN-1:0]	if_inst_o
);

	logic [`XLEN-1:0]	pc;
	logic [`XLEN-1:0]	if_inst;

	// no stalls, pc advances every cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc		<= `RESET_PC;
			if_inst	<= '0;
		end
		else
		begin
			pc		<= pc + `XLEN'd4;
			if_inst	<= inst_i;
		end
	end

	assign inst_addr_o	= pc;
	assign if_inst_o	= if_inst;

endmodule

`default_nettype wire

// ==== design/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module regfile
(
	input  wire					clk,
	input  wire					rst,
	rf_read_if.rf				rf,
	input  wire					w_en_i,
	input  wire [`REG_AW-1:0]	w_addr_i,
	input  wire [`XLEN-1:0]		w_data_i
);

	logic [`XLEN-1:0]	regs [`REG_NUM];

	// write-through so a same-cycle write-back is seen by decode
	function automatic logic [`XLEN-1:0] read_port(
		input logic					en,
		input logic [`REG_AW-1:0]	addr
	);
		if (!en || addr == `NOP_REG)
			return '0;
		if (w_en_i && w_addr_i == addr)
			return w_data_i;
		return regs[addr];
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `REG_NUM; i++)
				regs[i] <= '0;
		end
		else if (w_en_i && w_addr_i != `NOP_REG)
		begin
			regs[w_addr_i] <= w_data_i;
		end
	end

	always_comb
	begin
		rf.r1_data = read_port(rf.r1_en, rf.r1_addr);
		rf.r2_data = read_port(rf.r2_en, rf.r2_addr);
	end

endmodule

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	// major opcodes handled by this core
	typedef enum logic [6:0]
	{
		OP_LUI	= 7'b0110111,
		OP_OPI	= 7'b0010011,
		OP_OP	= 7'b0110011
	} opcode_e;

	// one value per alu group, shared by OP and OP-IMM
	typedef enum logic [2:0]
	{
		F3_ADD	= 3'b000,
		F3_SLL	= 3'b001,
		F3_SLT	= 3'b010,
		F3_SLTU	= 3'b011,
		F3_XOR	= 3'b100,
		F3_SRL	= 3'b101,
		F3_OR	= 3'b110,
		F3_AND	= 3'b111
	} funct3_e;

	// alt selects sub and sra
	typedef enum logic [6:0]
	{
		F7_BASE	= 7'b0000000,
		F7_ALT	= 7'b0100000
	} funct7_e;

endpackage

`default_nettype wire

// ==== sim.f ====
+incdir+design
design/rv_isa_pkg.sv
design/core_pipe_pkg.sv
design/core_ifs.sv
design/fetch_stage.sv
design/decode_stage.sv
design/regfile.sv
design/exec_pipe.sv
design/core_top.sv
tests/core_tb.sv

// ==== tests/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "core_consts.svh"

module core_tb
	import rv_isa_pkg::*;
();

	localparam int ROM_WORDS		= 256;
	localparam int ROM_BYTES		= ROM_WORDS * 4;
	localparam int RESET_CYCLES		= 3;
	localparam int FIRST_WB_LAT		= 4;
	localparam int ENTRY_TIMEOUT	= 32;
	localparam int DRAIN_CYCLES		= 8;
	localparam int RANDOM_LEN		= 200;

	logic					clk;
	logic					rst;
	logic [`XLEN-1:0]		inst_i = '0;
	logic [`XLEN-1:0]		inst_addr_o;
	logic					wb_en_o;
	logic [`REG_AW-1:0]		wb_addr_o;
	logic [`XLEN-1:0]		wb_data_o;

	logic [`XLEN-1:0]		rom [ROM_WORDS];
	logic [`XLEN-1:0]		prog [$];
	logic [`XLEN-1:0]		model_regs [`REG_NUM];
	logic [`REG_AW-1:0]		exp_addr [$];
	logic [`XLEN-1:0]		exp_data [$];
	logic [31:0]			lfsr_state = 32'd39;

	string	cur_name;
	int		cur_errors;
	int		first_wait;
	int		tests_run;
	int		tests_failed;
	int		total_checks;
	int		total_errors;

	core_top DUT
	(
		.clk			(clk),
		.rst			(rst),
		.inst_i			(inst_i),
		.inst_addr_o	(inst_addr_o),
		.wb_en_o		(wb_en_o),
		.wb_addr_o		(wb_addr_o),
		.wb_data_o		(wb_data_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// instruction rom, zero words past the program
	always @(negedge clk)
	begin
		if (inst_addr_o < ROM_BYTES)
			inst_i <= rom[inst_addr_o[9:2]];
		else
			inst_i <= '0;
	end

	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = next_lfsr(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] u_type(input int rd, input int imm20);
		return {imm20[19:0], rd[4:0], OP_LUI};
	endfunction

	function automatic logic [31:0] i_type(input logic [2:0] f3, input int rd, input int rs1,
		input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], OP_OPI};
	endfunction

	function automatic logic [31:0] shift_imm(input logic [2:0] f3, input logic [6:0] f7,
		input int rd, input int rs1, input int shamt);
		return {f7, shamt[4:0], rs1[4:0], f3, rd[4:0], OP_OPI};
	endfunction

	function automatic logic [31:0] r_type(input logic [2:0] f3, input logic [6:0] f7,
		input int rd, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_OP};
	endfunction

	// rv32i semantics for one instruction
	task automatic model_execute(input logic [31:0] inst);
		logic [6:0]		opc;
		logic [6:0]		f7;
		logic [2:0]		f3;
		logic [4:0]		rd;
		logic [4:0]		rs1;
		logic [4:0]		rs2;
		logic [31:0]	a;
		logic [31:0]	b;
		logic [31:0]	res;
		logic			valid;
		logic			alt;

		opc		= inst[6:0];
		rd		= inst[11:7];
		f3		= inst[14:12];
		rs1		= inst[19:15];
		rs2		= inst[24:20];
		f7		= inst[31:25];
		a		= model_regs[rs1];
		b		= model_regs[rs2];
		alt		= (f7 == F7_ALT);
		valid	= 1'b0;
		res		= '0;

		if (opc == OP_LUI)
		begin
			valid	= 1'b1;
			res		= {inst[31:12], 12'h000};
		end
		else if (opc == OP_OPI || opc == OP_OP)
		begin
			if (opc == OP_OPI)
			begin
				valid	= 1'b1;
				b		= {{20{inst[31]}}, inst[31:20]};
				if (f3 == F3_SLL)
					valid = (f7 == F7_BASE);
				else if (f3 == F3_SRL)
					valid = (f7 == F7_BASE) || alt;
				if (f3 == F3_SLL || f3 == F3_SRL)
					b = {27'b0, rs2};
			end
			else
				valid = (f7 == F7_BASE) || (alt && (f3 == F3_ADD || f3 == F3_SRL));
			case (f3)
				F3_ADD:		res = (alt && opc == OP_OP) ? a - b : a + b;
				F3_SLL:		res = a << b[4:0];
				F3_SLT:		res = {31'b0, $signed(a) < $signed(b)};
				F3_SLTU:	res = {31'b0, a < b};
				F3_XOR:		res = a ^ b;
				F3_SRL:		res = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
				F3_OR:		res = a | b;
				default:	res = a & b;
			endcase
		end

		if (valid && rd != 5'd0)
		begin
			model_regs[rd] = res;
			exp_addr.push_back(rd);
			exp_data.push_back(res);
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < ROM_WORDS; i++)
			rom[i] = '0;
		foreach (prog[i])
			rom[i] = prog[i];
		for (int i = 0; i < `REG_NUM; i++)
			model_regs[i] = '0;
		exp_addr.delete();
		exp_data.delete();
		foreach (prog[i])
			model_execute(prog[i]);
	endtask

	task automatic pulse_reset();
		@(negedge clk);
		rst = 1'b1;
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			@(negedge clk);
			total_checks += 2;
			assert (!wb_en_o)
			else
			begin
				$display("[FAIL] %0t: %s write-back during reset", $time, cur_name);
				cur_errors++;
			end
			assert (inst_addr_o == `RESET_PC)
			else
			begin
				$display("[FAIL] %0t: %s fetch address %h during reset, expected %h",
					$time, cur_name, inst_addr_o, `RESET_PC);
				cur_errors++;
			end
		end
		rst = 1'b0;
	endtask

	task automatic wait_entry(output bit ok, output int waited);
		ok = 1'b0;
		waited = 0;
		while (!ok && waited < ENTRY_TIMEOUT)
		begin
			@(negedge clk);
			if (wb_en_o)
				ok = 1'b1;
			else
				waited++;
		end
	endtask

	task automatic execute_program();
		bit	ok;
		int	waited;

		ok = 1'b1;
		first_wait = -1;
		load_program();
		pulse_reset();
		for (int i = 0; i < exp_data.size(); i++)
		begin
			wait_entry(ok, waited);
			if (!ok)
			begin
				$display("%s: write-back %0d of %0d did not arrive within %0d cycles",
					cur_name, i + 1, exp_data.size(), ENTRY_TIMEOUT);
				cur_errors++;
				break;
			end
			if (i == 0)
				first_wait = waited;
			total_checks += 2;
			assert (wb_addr_o == exp_addr[i])
			else
			begin
				$display("[FAIL] %0t: %s entry %0d wrote x%0d, expected x%0d",
					$time, cur_name, i, wb_addr_o, exp_addr[i]);
				cur_errors++;
			end
			assert (wb_data_o == exp_data[i])
			else
			begin
				$display("[FAIL] %0t: %s entry %0d data %h, expected %h",
					$time, cur_name, i, wb_data_o, exp_data[i]);
				cur_errors++;
			end
		end

		// nothing may follow the last expected write
		for (int i = 0; ok && i < DRAIN_CYCLES; i++)
		begin
			@(negedge clk);
			total_checks++;
			assert (!wb_en_o)
			else
			begin
				$display("[FAIL] %0t: %s extra write-back to x%0d", $time, cur_name, wb_addr_o);
				cur_errors++;
			end
		end
	endtask

	task automatic start_test(input string name);
		cur_name = name;
		cur_errors = 0;
		prog.delete();
	endtask

	task automatic finish_test();
		tests_run++;
		total_errors += cur_errors;
		if (cur_errors != 0)
			tests_failed++;
		$display("%s: %s (%0d errors)", cur_name, cur_errors == 0 ? "passed" : "failed",
			cur_errors);
	endtask

	task automatic reset_latency_test();
		start_test("reset");
		prog.push_back(u_type(1, 20'h12345));
		prog.push_back(i_type(F3_ADD, 2, 1, 12'h678));
		// start once, then reset again with both writes still in the pipeline
		load_program();
		pulse_reset();
		repeat (FIRST_WB_LAT - 1) @(negedge clk);
		execute_program();
		// the release edge is the first of the quiet cycles
		total_checks++;
		assert (first_wait + 1 == FIRST_WB_LAT)
		else
		begin
			$display("[FAIL] %0t: first write-back after %0d cycles, expected %0d",
				$time, first_wait + 1, FIRST_WB_LAT);
			cur_errors++;
		end
		finish_test();
	endtask

	task automatic immediate_ops_test();
		start_test("immediate ops");
		prog.push_back(u_type(1, 20'h80000));
		prog.push_back(i_type(F3_ADD, 2, 0, -5));
		prog.push_back(i_type(F3_ADD, 3, 2, -2048));
		prog.push_back(i_type(F3_SLT, 4, 2, -4));
		prog.push_back(i_type(F3_SLT, 5, 2, -6));
		prog.push_back(i_type(F3_SLTU, 6, 2, -1));
		prog.push_back(i_type(F3_SLTU, 7, 0, -1));
		prog.push_back(i_type(F3_SLTU, 8, 2, 5));
		prog.push_back(i_type(F3_SLT, 9, 1, 0));
		prog.push_back(i_type(F3_XOR, 10, 2, -1));
		prog.push_back(i_type(F3_OR, 11, 0, -256));
		prog.push_back(i_type(F3_AND, 12, 2, -16));
		prog.push_back(i_type(F3_AND, 13, 1, 2047));
		prog.push_back(i_type(F3_ADD, 14, 1, -1));
		prog.push_back(u_type(15, 20'hFFFFF));
		execute_program();
		finish_test();
	endtask

	task automatic register_ops_test();
		start_test("register ops");
		prog.push_back(u_type(1, 20'h80000));
		prog.push_back(i_type(F3_ADD, 1, 1, -1));
		prog.push_back(u_type(2, 20'h80000));
		prog.push_back(i_type(F3_OR, 3, 0, 1));
		prog.push_back(u_type(4, 20'hABCDE));
		prog.push_back(i_type(F3_OR, 4, 4, 12'h123));
		prog.push_back(i_type(F3_OR, 5, 0, -3));
		prog.push_back(r_type(F3_ADD, F7_BASE, 6, 1, 3));
		prog.push_back(r_type(F3_ADD, F7_ALT, 7, 2, 3));
		prog.push_back(r_type(F3_ADD, F7_ALT, 8, 0, 2));
		prog.push_back(r_type(F3_ADD, F7_BASE, 9, 4, 5));
		prog.push_back(r_type(F3_SLT, F7_BASE, 10, 2, 1));
		prog.push_back(r_type(F3_SLT, F7_BASE, 11, 1, 2));
		prog.push_back(r_type(F3_SLTU, F7_BASE, 12, 1, 2));
		prog.push_back(r_type(F3_SLTU, F7_BASE, 13, 5, 3));
		prog.push_back(r_type(F3_AND, F7_BASE, 14, 4, 5));
		prog.push_back(r_type(F3_OR, F7_BASE, 15, 4, 3));
		prog.push_back(r_type(F3_XOR, F7_BASE, 16, 4, 5));
		execute_program();
		finish_test();
	endtask

	task automatic shift_ops_test();
		start_test("shifts");
		prog.push_back(u_type(1, 20'h80F00));
		prog.push_back(i_type(F3_OR, 1, 1, 12'h0F0));
		// low five bits 3 and 31, upper bits set
		prog.push_back(i_type(F3_OR, 2, 0, -29));
		prog.push_back(i_type(F3_OR, 3, 0, 12'h7FF));
		prog.push_back(shift_imm(F3_SLL, F7_BASE, 4, 1, 4));
		prog.push_back(shift_imm(F3_SRL, F7_BASE, 5, 1, 4));
		prog.push_back(shift_imm(F3_SRL, F7_ALT, 6, 1, 4));
		prog.push_back(shift_imm(F3_SRL, F7_ALT, 7, 1, 31));
		prog.push_back(shift_imm(F3_SLL, F7_BASE, 8, 1, 0));
		prog.push_back(r_type(F3_SLL, F7_BASE, 9, 1, 2));
		prog.push_back(r_type(F3_SRL, F7_BASE, 10, 1, 2));
		prog.push_back(r_type(F3_SRL, F7_ALT, 11, 1, 2));
		prog.push_back(r_type(F3_SRL, F7_ALT, 12, 1, 3));
		prog.push_back(r_type(F3_SRL, F7_BASE, 13, 1, 3));
		prog.push_back(r_type(F3_SLL, F7_BASE, 14, 1, 3));
		execute_program();
		finish_test();
	endtask

	task automatic hazard_test();
		start_test("hazards");
		prog.push_back(i_type(F3_ADD, 1, 0, 5));
		prog.push_back(i_type(F3_ADD, 2, 1, 3));
		prog.push_back(i_type(F3_ADD, 3, 1, 7));
		prog.push_back(i_type(F3_ADD, 4, 1, 9));
		prog.push_back(r_type(F3_ADD, F7_BASE, 5, 2, 3));
		prog.push_back(r_type(F3_ADD, F7_BASE, 6, 5, 5));
		prog.push_back(r_type(F3_ADD, F7_ALT, 7, 6, 2));
		prog.push_back(i_type(F3_ADD, 8, 0, 1));
		prog.push_back(i_type(F3_ADD, 8, 8, 1));
		prog.push_back(i_type(F3_ADD, 8, 8, 1));
		prog.push_back(i_type(F3_ADD, 8, 8, 1));
		// ex result must win over mem
		prog.push_back(i_type(F3_ADD, 9, 0, 10));
		prog.push_back(i_type(F3_ADD, 9, 0, 20));
		prog.push_back(r_type(F3_ADD, F7_BASE, 10, 9, 9));
		// mem result must win over write-back
		prog.push_back(i_type(F3_ADD, 11, 0, 1));
		prog.push_back(i_type(F3_ADD, 11, 0, 2));
		prog.push_back(i_type(F3_ADD, 20, 0, 0));
		prog.push_back(r_type(F3_ADD, F7_BASE, 12, 11, 11));
		prog.push_back(i_type(F3_ADD, 0, 0, 123));
		prog.push_back(r_type(F3_ADD, F7_BASE, 13, 0, 0));
		prog.push_back(u_type(0, 20'hFFFFF));
		prog.push_back(i_type(F3_OR, 14, 0, 0));
		// load, all ones, zero word, bad funct7 forms
		prog.push_back(32'h0000_2083);
		prog.push_back(32'hFFFF_FFFF);
		prog.push_back(32'h0000_0000);
		prog.push_back(r_type(F3_XOR, F7_ALT, 1, 2, 3));
		prog.push_back(shift_imm(F3_SLL, F7_ALT, 1, 1, 3));
		prog.push_back(r_type(F3_ADD, F7_BASE, 15, 1, 0));
		prog.push_back(r_type(F3_ADD, F7_BASE, 16, 0, 0));
		execute_program();
		finish_test();
	endtask

	task automatic build_random_program(input int count);
		int	kind;
		int	rd;
		int	rs1;
		int	rs2;
		int	imm;

		for (int i = 0; i < count; i++)
		begin
			kind	= random_bits(5) % 20;
			// few registers so that hazards are common
			rd		= random_bits(3);
			rs1		= random_bits(3);
			rs2		= random_bits(3);
			imm		= random_bits(20);
			case (kind)
				0:			prog.push_back(u_type(rd, imm));
				1:			prog.push_back(i_type(F3_ADD, rd, rs1, imm));
				2:			prog.push_back(i_type(F3_SLT, rd, rs1, imm));
				3:			prog.push_back(i_type(F3_SLTU, rd, rs1, imm));
				4:			prog.push_back(i_type(F3_XOR, rd, rs1, imm));
				5:			prog.push_back(i_type(F3_OR, rd, rs1, imm));
				6:			prog.push_back(i_type(F3_AND, rd, rs1, imm));
				7:			prog.push_back(shift_imm(F3_SLL, F7_BASE, rd, rs1, imm));
				8:			prog.push_back(shift_imm(F3_SRL, F7_BASE, rd, rs1, imm));
				9:			prog.push_back(shift_imm(F3_SRL, F7_ALT, rd, rs1, imm));
				10:			prog.push_back(r_type(F3_ADD, F7_BASE, rd, rs1, rs2));
				11:			prog.push_back(r_type(F3_ADD, F7_ALT, rd, rs1, rs2));
				12:			prog.push_back(r_type(F3_SLL, F7_BASE, rd, rs1, rs2));
				13:			prog.push_back(r_type(F3_SLT, F7_BASE, rd, rs1, rs2));
				14:			prog.push_back(r_type(F3_SLTU, F7_BASE, rd, rs1, rs2));
				15:			prog.push_back(r_type(F3_XOR, F7_BASE, rd, rs1, rs2));
				16:			prog.push_back(r_type(F3_SRL, F7_BASE, rd, rs1, rs2));
				17:			prog.push_back(r_type(F3_SRL, F7_ALT, rd, rs1, rs2));
				18:			prog.push_back(r_type(F3_OR, F7_BASE, rd, rs1, rs2));
				default:	prog.push_back(r_type(F3_AND, F7_BASE, rd, rs1, rs2));
			endcase
		end
	endtask

	task automatic random_program_test();
		start_test("random program");
		build_random_program(RANDOM_LEN);
		execute_program();
		finish_test();
	endtask

	initial
	begin
		rst = 1'b1;
		tests_run = 0;
		tests_failed = 0;
		total_checks = 0;
		total_errors = 0;

		reset_latency_test();
		immediate_ops_test();
		register_ops_test();
		shift_ops_test();
		hazard_test();
		random_program_test();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, total_checks, total_errors);
		if (tests_failed == 0 && total_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
